/* ctrlDefines.svh */
// Control unit constants
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

`define CTRL_XLEN        32             // Instruction width
`define CTRL_REGW        5              // Register index width

// Feature enables
`define CTRL_M_EN        1              // Multiply and divide
`define CTRL_ZICSR_EN    1              // CSR and privileged instructions
`define CTRL_ZIFENCEI_EN 1              // Instruction fence

// Field positions
`define CTRL_RD_LSB      7
`define CTRL_F3_LSB      12
`define CTRL_RS1_LSB     15
`define CTRL_RS2_LSB     20
`define CTRL_F7_LSB      25

//////////////////////////////
// Opcodes
`define OP_LOAD          7'b0000011
`define OP_FENCE         7'b0001111
`define OP_IMM           7'b0010011
`define OP_AUIPC         7'b0010111
`define OP_STORE         7'b0100011
`define OP_REG           7'b0110011
`define OP_LUI           7'b0110111
`define OP_BRANCH        7'b1100011
`define OP_JALR          7'b1100111
`define OP_JAL           7'b1101111
`define OP_SYSTEM        7'b1110011

// Funct7 values
`define CTRL_F7_ZERO     7'b0000000     // Most R-type ops
`define CTRL_F7_ALT      7'b0100000     // sub and sra
`define CTRL_F7_MULDIV   7'b0000001     // M extension
`define CTRL_F7_SFENCE   7'b0001001     // sfence.vma

`endif

/* ctrlPkg.sv */
// Pipeline control types
`include "ctrlDefines.svh"

package ctrlPkg;

  typedef enum logic [2:0] {
    IMM_I = 3'b000,                     // Loads, ALU immediates, jalr
    IMM_S = 3'b001,                     // Stores
    IMM_B = 3'b010,                     // Branches
    IMM_J = 3'b011,                     // jal
    IMM_U = 3'b100                      // lui and auipc
  } immSrcT;

  typedef enum logic [1:0] {
    RES_ALU  = 2'b00,
    RES_LOAD = 2'b01,
    RES_CSR  = 2'b10,
    RES_MDU  = 2'b11
  } resultSrcT;

  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,                   // Register file value
    FWD_WB   = 2'b01,                   // Writeback result
    FWD_MEM  = 2'b10                    // Memory stage ALU result
  } fwdSelT;

  typedef struct packed {
    logic read;                         // Bit 1
    logic write;                        // Bit 0
  } memRwT;

  //////////////////////////////
  // Stage payloads
  typedef struct packed {
    logic                  regWrite;
    resultSrcT             resultSrc;
    memRwT                 memRw;
    logic                  jump;
    logic                  branch;
    logic                  aluSrcA;       // PC as operand A
    logic                  aluSrcB;       // Immediate as operand B
    logic                  aluResultSrc;  // Pass operand B through
    logic [2:0]            aluSelect;     // ALU output mux
    logic                  subArith;      // Invert B or arithmetic shift
    logic                  csrRead;
    logic                  csrWrite;
    logic                  privileged;
    logic                  fence;         // fence.i or sfence.vma
    logic                  mdu;           // Multiply or divide
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`CTRL_REGW-1:0] rs1;
    logic [`CTRL_REGW-1:0] rs2;
    logic [`CTRL_REGW-1:0] rd;
    logic                  valid;
  } exCtrlT;

  typedef struct packed {
    logic                  regWrite;
    resultSrcT             resultSrc;
    memRwT                 memRw;
    logic                  csrRead;
    logic                  csrWrite;
    logic                  privileged;
    logic [2:0]            funct3;
    logic                  fence;
    logic                  intDiv;        // Divide result arrives late
    logic [`CTRL_REGW-1:0] rd;
    logic                  valid;
  } memCtrlT;

  typedef struct packed {
    logic                  regWrite;
    resultSrcT             resultSrc;
    logic                  intDiv;
    logic [`CTRL_REGW-1:0] rd;
  } wbCtrlT;

endpackage

/* stageReg.sv */
// Pipeline control register
`timescale 1ns/1ps

module stageReg #(
  parameter type payloadT = logic       // Struct or bit held by the stage
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    flush,                // Has priority over en
  input  logic    en,                   // Inverse of the stage stall
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;                          // Empty stage
    end else if (flush) begin
      q <= '0;                          // Bubble
    end else if (en) begin
      q <= d;
    end
  end

  // A cleared stage holds known zeros into the next cycle
  assert property (@(posedge clk) (!arstN || flush) |=> !$isunknown(q))
    else $error("stageReg: unknown contents after reset or flush");

endmodule

/* decodeStage.sv */
// Instruction decoder
`timescale 1ns/1ps
`include "ctrlDefines.svh"

module decodeStage (
  input  logic [`CTRL_XLEN-1:0]  instr,
  input  logic                   stall,
  input  logic                   flush,
  input  logic                   clk,
  input  logic                   arstN,
  output ctrlPkg::immSrcT        immSrc,
  output logic                   illegal,    // Unsupported encoding
  output logic                   jump,
  output logic                   branch,
  output logic [`CTRL_REGW-1:0]  rs1,
  output logic [`CTRL_REGW-1:0]  rs2,
  output ctrlPkg::memRwT         memRw,
  output ctrlPkg::exCtrlT        exCtrl,     // Controls handed to Execute
  output logic                   validD
);

  localparam int CW = 18;                    // Main decoder word width

  logic [6:0]            op;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`CTRL_REGW-1:0] rd;
  logic                  f7Zero, f7Alt;
  logic                  iFunct, rFunct, mFunct, lFunct, sFunct, bFunct;
  logic                  jrFunct, fenceFunct, pFunct, csrFunct;
  logic [CW-1:0]         ctrlWord;
  logic [2:0]            immBits;
  logic [1:0]            resultBits;
  logic                  regWriteD, aluSrcAD, aluSrcBD, aluOpD, aluResultSrcD;
  logic                  csrReadD, csrWriteD, privilegedD, mduD, fenceD;
  logic                  subD, sraD, sltD, sltuD, subArithD;

  assign op     = instr[6:0];
  assign funct3 = instr[`CTRL_F3_LSB +: 3];
  assign funct7 = instr[`CTRL_F7_LSB +: 7];
  assign rd     = instr[`CTRL_RD_LSB +: `CTRL_REGW];
  assign rs1    = instr[`CTRL_RS1_LSB +: `CTRL_REGW];
  assign rs2    = instr[`CTRL_RS2_LSB +: `CTRL_REGW];

  //////////////////////////////
  // Exact legality of funct fields
  assign f7Zero     = (funct7 == `CTRL_F7_ZERO);
  assign f7Alt      = (funct7 == `CTRL_F7_ALT);
  assign iFunct     = ((funct3 != 3'b001) & (funct3 != 3'b101)) |      // No shift
                      (funct3 == 3'b001 & f7Zero) | (funct3 == 3'b101 & (f7Zero | f7Alt));
  assign rFunct     = f7Zero | ((funct3 == 3'b000 | funct3 == 3'b101) & f7Alt);
  assign mFunct     = (`CTRL_M_EN != 0) & (funct7 == `CTRL_F7_MULDIV);
  assign lFunct     = (funct3 != 3'b011) & (funct3[2:1] != 2'b11);   // lb lh lw lbu lhu
  assign sFunct     = (funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b010);
  assign bFunct     = (funct3[2:1] != 2'b01);
  assign jrFunct    = (funct3 == 3'b000);
  assign fenceFunct = (funct3 == 3'b000) | ((`CTRL_ZIFENCEI_EN != 0) & funct3 == 3'b001);
  assign pFunct     = (funct3 == 3'b000) & (rd == '0);               // ecall ebreak xret wfi sfence
  assign csrFunct   = (funct3[1:0] != 2'b00);

  // Main decoder
  // regWrite_imm_srcA_srcB_memRw_result_branch_aluOp_jump_aluRes_csrRd_priv_mdu_illegal
  always_comb begin
    ctrlWord = 18'b0_000_0_0_00_00_0_0_0_0_0_0_0_1;                   // Illegal unless matched
    case (op)
      `OP_LOAD:   if (lFunct)     ctrlWord = 18'b1_000_0_1_10_01_0_0_0_0_0_0_0_0;
      `OP_FENCE:  if (fenceFunct) ctrlWord = 18'b0_000_0_0_00_00_0_0_0_0_0_0_0_0;
      `OP_IMM:    if (iFunct)     ctrlWord = 18'b1_000_0_1_00_00_0_1_0_0_0_0_0_0;
      `OP_AUIPC:                  ctrlWord = 18'b1_100_1_1_00_00_0_0_0_0_0_0_0_0;
      `OP_STORE:  if (sFunct)     ctrlWord = 18'b0_001_0_1_01_00_0_0_0_0_0_0_0_0;
      `OP_REG:    if (rFunct)     ctrlWord = 18'b1_000_0_0_00_00_0_1_0_0_0_0_0_0;
                  else if (mFunct) ctrlWord = 18'b1_000_0_0_00_11_0_0_0_0_0_0_1_0;
      `OP_LUI:                    ctrlWord = 18'b1_100_0_1_00_00_0_0_0_1_0_0_0_0;
      `OP_BRANCH: if (bFunct)     ctrlWord = 18'b0_010_1_1_00_00_1_0_0_0_0_0_0_0;
      `OP_JALR:   if (jrFunct)    ctrlWord = 18'b1_000_0_1_00_00_0_0_1_1_0_0_0_0;
      `OP_JAL:                    ctrlWord = 18'b1_011_1_1_00_00_0_0_1_1_0_0_0_0;
      `OP_SYSTEM: if (`CTRL_ZICSR_EN != 0) begin
                    if (pFunct)        ctrlWord = 18'b0_000_0_0_00_00_0_0_0_0_0_1_0_0;
                    else if (csrFunct) ctrlWord = 18'b1_000_0_0_00_10_0_0_0_0_1_0_0_0;
                  end
      default: ;
    endcase
  end

  assign {regWriteD, immBits, aluSrcAD, aluSrcBD, memRw, resultBits, branch, aluOpD,
          jump, aluResultSrcD, csrReadD, privilegedD, mduD, illegal} = ctrlWord;
  assign immSrc = ctrlPkg::immSrcT'(immBits);

  // Set and clear with a zero source leave the CSR alone
  assign csrWriteD = csrReadD & ~(funct3[1] & (rs1 == '0));
  assign fenceD    = ~illegal & (((op == `OP_FENCE) & (funct3 == 3'b001)) |
                                 (privilegedD & (funct7 == `CTRL_F7_SFENCE)));

  assign subD      = (funct3 == 3'b000) & funct7[5] & op[5];          // op[5] keeps addi out
  assign sraD      = (funct3 == 3'b101) & funct7[5];
  assign sltD      = (funct3 == 3'b010);
  assign sltuD     = (funct3 == 3'b011);
  assign subArithD = aluOpD & (subD | sraD | sltD | sltuD);

  stageReg #(.payloadT(logic)) validReg (
    .clk, .arstN, .flush, .en(~stall), .d(1'b1), .q(validD)
  );

  assign exCtrl = '{
    regWrite: regWriteD, resultSrc: ctrlPkg::resultSrcT'(resultBits), memRw: memRw,
    jump: jump, branch: branch, aluSrcA: aluSrcAD, aluSrcB: aluSrcBD,
    aluResultSrc: aluResultSrcD, aluSelect: (aluOpD ? funct3 : 3'b000),  // add for addresses
    subArith: subArithD, csrRead: csrReadD, csrWrite: csrWriteD,
    privileged: privilegedD, fence: fenceD, mdu: mduD,
    funct3: funct3, funct7: funct7, rs1: rs1, rs2: rs2, rd: rd, valid: validD
  };

  // Nothing illegal may write state further down the pipe
  assert property (@(posedge clk) disable iff (!arstN)
    illegal |-> !exCtrl.regWrite && !exCtrl.csrWrite && exCtrl.memRw == '0)
    else $error("decodeStage: illegal instruction carries write controls");

endmodule

/* executeStage.sv */
// Execute stage control
`timescale 1ns/1ps

module executeStage (
  input  logic              clk,
  input  logic              arstN,
  input  logic              stall,
  input  logic              flush,
  input  ctrlPkg::exCtrlT   exCtrlD,
  input  logic [1:0]        flags,          // {eq, lt}
  output ctrlPkg::exCtrlT   exCtrlE,
  output logic              pcSrc,          // Redirect fetch
  output logic              branchSigned,
  output logic              mduActive,
  output ctrlPkg::memCtrlT  memCtrl         // Payload for Memory
);

  logic eq, lt;
  logic branchFlag;
  logic taken;
  logic intDiv;

  stageReg #(.payloadT(ctrlPkg::exCtrlT)) ctrlRegE (
    .clk, .arstN, .flush, .en(~stall), .d(exCtrlD), .q(exCtrlE)
  );

  //////////////////////////////
  // Branch resolution
  assign {eq, lt}     = flags;
  assign branchFlag   = exCtrlE.funct3[2] ? lt : eq;            // blt/bge family use lt
  assign taken        = branchFlag ^ exCtrlE.funct3[0];         // bne bge bgeu invert
  assign pcSrc        = exCtrlE.jump | (exCtrlE.branch & taken);
  assign branchSigned = exCtrlE.branch & (exCtrlE.funct3[2:1] != 2'b11);  // Not bltu/bgeu

  assign mduActive    = (exCtrlE.resultSrc == ctrlPkg::RES_MDU);
  assign intDiv       = exCtrlE.mdu & exCtrlE.funct3[2];        // div divu rem remu

  assign memCtrl = '{
    regWrite: exCtrlE.regWrite, resultSrc: exCtrlE.resultSrc, memRw: exCtrlE.memRw,
    csrRead: exCtrlE.csrRead, csrWrite: exCtrlE.csrWrite, privileged: exCtrlE.privileged,
    funct3: exCtrlE.funct3, fence: exCtrlE.fence, intDiv: intDiv,
    rd: exCtrlE.rd, valid: exCtrlE.valid
  };

  // Redirect only comes from a control-transfer instruction in Execute
  assert property (@(posedge clk) disable iff (!arstN)
    $rose(pcSrc) |-> exCtrlE.jump || exCtrlE.branch)
    else $error("executeStage: redirect without jump or branch");

endmodule

/* memWbStage.sv */
// Memory and Writeback control
`timescale 1ns/1ps

module memWbStage (
  input  logic              clk,
  input  logic              arstN,
  input  logic              stallM,
  input  logic              flushM,
  input  logic              stallW,
  input  logic              flushW,
  input  ctrlPkg::memCtrlT  memCtrlE,
  output ctrlPkg::memCtrlT  memCtrl,
  output ctrlPkg::wbCtrlT   wbCtrl,
  output logic              csrWriteFence,     // Flush the front end
  output logic              invalidateICache   // fence.i in Memory
);

  ctrlPkg::wbCtrlT wbNext;

  stageReg #(.payloadT(ctrlPkg::memCtrlT)) ctrlRegM (
    .clk, .arstN, .flush(flushM), .en(~stallM), .d(memCtrlE), .q(memCtrl)
  );

  // Writeback keeps only what the register file needs
  assign wbNext = '{
    regWrite: memCtrl.regWrite, resultSrc: memCtrl.resultSrc,
    intDiv: memCtrl.intDiv, rd: memCtrl.rd
  };

  stageReg #(.payloadT(ctrlPkg::wbCtrlT)) ctrlRegW (
    .clk, .arstN, .flush(flushW), .en(~stallW), .d(wbNext), .q(wbCtrl)
  );

  assign csrWriteFence    = memCtrl.csrWrite | memCtrl.fence;
  assign invalidateICache = memCtrl.fence & ~memCtrl.privileged;  // sfence.vma is privileged

endmodule

/* hazardUnit.sv */
// Forwarding and stall detection
`timescale 1ns/1ps
`include "ctrlDefines.svh"

module hazardUnit (
  input  logic                   clk,          // Assertion sampling only
  input  logic [`CTRL_REGW-1:0]  rs1D,
  input  logic [`CTRL_REGW-1:0]  rs2D,
  input  ctrlPkg::memRwT         memRwD,
  input  ctrlPkg::exCtrlT        exCtrlE,
  input  logic [`CTRL_REGW-1:0]  rdM,
  input  logic                   regWriteM,
  input  logic [`CTRL_REGW-1:0]  rdW,
  input  logic                   regWriteW,
  output ctrlPkg::fwdSelT        forwardA,
  output ctrlPkg::fwdSelT        forwardB,
  output logic                   loadStall,    // Load-use
  output logic                   storeStall,   // Load behind a store
  output logic                   structuralStall
);

  logic matchDE;
  logic csrRdStall, mduStall;

  // Youngest producer wins and x0 never forwards
  function automatic ctrlPkg::fwdSelT pickFwd(input logic [`CTRL_REGW-1:0] src);
    ctrlPkg::fwdSelT sel;
    sel = ctrlPkg::FWD_NONE;
    if (src != '0) begin
      if (regWriteM && (src == rdM)) sel = ctrlPkg::FWD_MEM;
      else if (regWriteW && (src == rdW)) sel = ctrlPkg::FWD_WB;
    end
    return sel;
  endfunction

  always_comb begin
    forwardA = pickFwd(exCtrlE.rs1);
    forwardB = pickFwd(exCtrlE.rs2);
  end

  //////////////////////////////
  // Results that cannot bypass in time
  assign matchDE    = ((rs1D == exCtrlE.rd) | (rs2D == exCtrlE.rd)) & (exCtrlE.rd != '0);
  assign loadStall  = exCtrlE.memRw.read & matchDE;
  assign storeStall = memRwD.read & exCtrlE.memRw.write;
  assign csrRdStall = exCtrlE.csrRead & matchDE;
  assign mduStall   = exCtrlE.mdu & matchDE;       // Multiply and divide take several cycles
  assign structuralStall = loadStall | storeStall | csrRdStall | mduStall;

  assert property (@(posedge clk) forwardA != 2'b11 && forwardB != 2'b11)
    else $error("hazardUnit: reserved forward select");

endmodule

/* controller.sv */
// Pipeline control unit
`timescale 1ns/1ps
`include "ctrlDefines.svh"

module controller (
  input  logic                   clk,
  input  logic                   arstN,
  // Decode
  input  logic [`CTRL_XLEN-1:0]  InstrD,
  input  logic                   StallD, FlushD,
  output ctrlPkg::immSrcT        ImmSrcD,
  output logic                   IllegalBaseInstrD,
  output logic                   JumpD, BranchD,
  output logic [`CTRL_REGW-1:0]  Rs1D, Rs2D,
  output logic                   LoadStallD, StoreStallD, StructuralStallD,
  // Execute
  input  logic                   StallE, FlushE,
  input  logic [1:0]             FlagsE,          // {eq, lt}
  output logic                   PCSrcE,
  output logic                   BranchSignedE,
  output logic                   MDUActiveE,
  output ctrlPkg::fwdSelT        ForwardAE, ForwardBE,
  // Memory
  input  logic                   StallM, FlushM,
  output ctrlPkg::memRwT         MemRWM,
  output logic                   CSRReadM, CSRWriteM, PrivilegedM,
  output logic [2:0]             Funct3M,
  output logic                   InvalidateICacheM,
  output logic                   InstrValidM,
  output logic                   CSRWriteFenceM,
  output logic [`CTRL_REGW-1:0]  RdM,
  // Writeback
  input  logic                   StallW, FlushW,
  output logic                   RegWriteW,
  output ctrlPkg::resultSrcT     ResultSrcW,
  output logic                   IntDivW,
  output logic [`CTRL_REGW-1:0]  RdW
);

  ctrlPkg::memRwT   memRwD;
  ctrlPkg::exCtrlT  exCtrlD, exCtrlE;
  ctrlPkg::memCtrlT memCtrlE, memCtrlM;
  ctrlPkg::wbCtrlT  wbCtrlW;

  decodeStage u_decode (
    .instr(InstrD), .stall(StallD), .flush(FlushD), .clk, .arstN,
    .immSrc(ImmSrcD), .illegal(IllegalBaseInstrD), .jump(JumpD), .branch(BranchD),
    .rs1(Rs1D), .rs2(Rs2D), .memRw(memRwD), .exCtrl(exCtrlD), .validD()
  );

  executeStage u_execute (
    .clk, .arstN, .stall(StallE), .flush(FlushE), .exCtrlD(exCtrlD), .flags(FlagsE),
    .exCtrlE(exCtrlE), .pcSrc(PCSrcE), .branchSigned(BranchSignedE),
    .mduActive(MDUActiveE), .memCtrl(memCtrlE)
  );

  memWbStage u_memWb (
    .clk, .arstN, .stallM(StallM), .flushM(FlushM), .stallW(StallW), .flushW(FlushW),
    .memCtrlE(memCtrlE), .memCtrl(memCtrlM), .wbCtrl(wbCtrlW),
    .csrWriteFence(CSRWriteFenceM), .invalidateICache(InvalidateICacheM)
  );

  hazardUnit u_hazard (
    .clk, .rs1D(Rs1D), .rs2D(Rs2D), .memRwD(memRwD), .exCtrlE(exCtrlE),
    .rdM(memCtrlM.rd), .regWriteM(memCtrlM.regWrite),
    .rdW(wbCtrlW.rd), .regWriteW(wbCtrlW.regWrite),
    .forwardA(ForwardAE), .forwardB(ForwardBE),
    .loadStall(LoadStallD), .storeStall(StoreStallD), .structuralStall(StructuralStallD)
  );

  //////////////////////////////
  // Stage fields out to the datapath
  assign MemRWM      = memCtrlM.memRw;
  assign CSRReadM    = memCtrlM.csrRead;
  assign CSRWriteM   = memCtrlM.csrWrite;
  assign PrivilegedM = memCtrlM.privileged;
  assign Funct3M     = memCtrlM.funct3;
  assign InstrValidM = memCtrlM.valid;
  assign RdM         = memCtrlM.rd;
  assign RegWriteW   = wbCtrlW.regWrite;
  assign ResultSrcW  = wbCtrlW.resultSrc;
  assign IntDivW     = wbCtrlW.intDiv;
  assign RdW         = wbCtrlW.rd;

endmodule

/* tbRefModel.svh */
// Control reference model
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
  logic       illegal;
  logic [2:0] immSrc;                   // I S B J U as 0 to 4
  logic       jump;
  logic       branch;
  logic       regWrite;
  logic [1:0] resultSrc;                // ALU load CSR MDU
  logic [1:0] memRw;                    // {read, write}
  logic       csrRead;
  logic       csrWrite;
  logic       mdu;
} refCtrlT;

// Expected controls straight from the RV32 encoding tables
function automatic refCtrlT decodeRef(input logic [31:0] ins);
  refCtrlT c;
  logic [2:0] f3;
  logic [6:0] f7;
  logic csrWr;
  f3 = ins[14:12];
  f7 = ins[31:25];
  c = '0;
  c.illegal = 1'b1;
  case (ins[6:0])
    `OP_LOAD:   if (f3 != 3'd3 && f3 < 3'd6) c = {1'b0, 3'd0, 3'b001, 2'd1, 2'b10, 3'b000};
    `OP_STORE:  if (f3 < 3'd3) c = {1'b0, 3'd1, 3'b000, 2'd0, 2'b01, 3'b000};
    `OP_BRANCH: if (f3 != 3'd2 && f3 != 3'd3) c = {1'b0, 3'd2, 3'b010, 2'd0, 2'b00, 3'b000};
    `OP_JAL:    c = {1'b0, 3'd3, 3'b101, 2'd0, 2'b00, 3'b000};
    `OP_JALR:   if (f3 == 3'd0) c = {1'b0, 3'd0, 3'b101, 2'd0, 2'b00, 3'b000};
    `OP_LUI, `OP_AUIPC: c = {1'b0, 3'd4, 3'b001, 2'd0, 2'b00, 3'b000};
    `OP_FENCE:  if (f3 < 3'd2) c = '0;
    `OP_IMM:
      if ((f3 != 3'd1 && f3 != 3'd5) || (f3 == 3'd1 && f7 == 7'h00) ||
          (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20)))
        c = {1'b0, 3'd0, 3'b001, 2'd0, 2'b00, 3'b000};
    `OP_REG:
      if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
        c = {1'b0, 3'd0, 3'b001, 2'd0, 2'b00, 3'b000};
      else if (f7 == 7'h01)
        c = {1'b0, 3'd0, 3'b001, 2'd3, 2'b00, 3'b001};
    `OP_SYSTEM:
      if (f3 == 3'd0 && ins[11:7] == 5'd0) c = '0;       // ecall and friends
      else if (f3 != 3'd0 && f3 != 3'd4) begin
        // csrrs csrrc csrrsi csrrci with a zero source only read
        csrWr = !((f3 == 3'd2 || f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7) &&
                  ins[19:15] == 5'd0);
        c = {1'b0, 3'd0, 3'b001, 2'd2, 2'b00, 1'b1, csrWr, 1'b0};
      end
    default: ;
  endcase
  return c;
endfunction

// Taken per branch kind, flags are {eq, lt}
function automatic logic takenRef(input logic [1:0] flags, input logic [2:0] f3);
  logic eq;
  logic lt;
  eq = flags[1];
  lt = flags[0];
  case (f3)
    3'd0:       return eq;              // beq
    3'd1:       return !eq;             // bne
    3'd4, 3'd6: return lt;              // blt bltu
    default:    return !lt;             // bge bgeu
  endcase
endfunction

// Memory wins over Writeback, x0 never forwards
function automatic logic [1:0] fwdRef(input logic [4:0] src, input logic [4:0] rdM,
                                      input logic wM, input logic [4:0] rdW, input logic wW);
  if (src == 5'd0) return 2'b00;
  if (wM && src == rdM) return 2'b10;
  if (wW && src == rdW) return 2'b01;
  return 2'b00;
endfunction

// ecall ebreak xret wfi and sfence.vma
function automatic logic privRef(input logic [31:0] ins);
  return ins[6:0] == `OP_SYSTEM && ins[14:12] == 3'd0 && ins[11:7] == 5'd0;
endfunction

// Instruction fetch fence
function automatic logic fenceIRef(input logic [31:0] ins);
  return ins[6:0] == `OP_FENCE && ins[14:12] == 3'd1;
endfunction

// Address translation fence
function automatic logic sfenceRef(input logic [31:0] ins);
  return privRef(ins) && ins[31:25] == 7'b0001001;
endfunction

`endif

/* tbController.sv */
// Control unit testbench
`timescale 1ns/1ps
`include "ctrlDefines.svh"

module tbController;

  `include "tbRefModel.svh"

  localparam int NUM_TESTS = 300;
  localparam int RST_CYCLES = 3;
  localparam time WATCHDOG_NS = (NUM_TESTS * 20 + RST_CYCLES) * 8;

  logic clk = 1'b0;
  logic arstN;
  logic [31:0] InstrD;
  logic StallD, FlushD, StallE, FlushE, StallM, FlushM, StallW, FlushW;
  logic [1:0] FlagsE;
  ctrlPkg::immSrcT ImmSrcD;
  ctrlPkg::fwdSelT ForwardAE, ForwardBE;
  ctrlPkg::memRwT MemRWM;
  ctrlPkg::resultSrcT ResultSrcW;
  logic IllegalBaseInstrD, JumpD, BranchD, PCSrcE, BranchSignedE, MDUActiveE;
  logic LoadStallD, StoreStallD, StructuralStallD, CSRReadM, CSRWriteM, PrivilegedM;
  logic InvalidateICacheM, InstrValidM, CSRWriteFenceM, RegWriteW, IntDivW;
  logic [2:0] Funct3M;
  logic [4:0] Rs1D, Rs2D, RdM, RdW, savedRd;
  integer seed = 42;
  int nLoadStall = 0, nOtherStall = 0, nFwdMem = 0, nFwdWb = 0, nTaken = 0;
  logic covOk;

  // Shadow pipeline of instruction words
  logic vD, vE, hE, vM, hM, hW;
  logic [31:0] iE, iM, iW;

  controller DUT (.*);

  always #4 clk = ~clk;                 // 8 ns period

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] assemble(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // Random encoding of one class, immediates ride in the f7 and rd slots
  function automatic logic [31:0] genInstr(input int unsigned cls);
    logic [6:0] f7, op;
    logic [4:0] rs1, rs2, rd;
    logic [2:0] f3;
    int unsigned k;
    f7 = 7'(pick(128));
    rs1 = 5'(pick(8));                  // Small range for dependences
    rs2 = 5'(pick(8));
    rd = 5'(pick(8));
    f3 = 3'(pick(8));
    k = pick(6);
    case (cls)
      0: begin
        op = `OP_LOAD;
        f3 = (k < 3) ? 3'(k) : 3'(k % 5 + 1);
      end
      1: begin
        op = `OP_STORE;
        f3 = 3'(k % 3);
      end
      2: begin
        op = `OP_BRANCH;
        f3 = (k < 2) ? 3'(k) : 3'(k + 2);
      end
      3: op = `OP_JAL;
      4: begin
        op = `OP_JALR;
        f3 = 3'd0;
      end
      5: begin
        op = `OP_IMM;
        if (f3 == 3'd1) f7 = 7'h00;
        if (f3 == 3'd5) f7 = k[0] ? 7'h20 : 7'h00;
      end
      6: begin
        op = `OP_REG;
        f7 = (k < 2) ? 7'h00 : (k < 4) ? 7'h20 : 7'h01;
        if (f7 == 7'h20) f3 = k[0] ? 3'd5 : 3'd0;
      end
      7: op = `OP_LUI;
      8: op = `OP_AUIPC;
      9: begin
        op = `OP_FENCE;
        f3 = 3'(k % 2);
      end
      10: begin
        op = `OP_SYSTEM;
        f3 = (k < 3) ? 3'(k + 1) : 3'(k + 2);
        if (pick(4) == 0) begin
          f3 = 3'd0;                    // ecall, xret, sfence.vma
          rd = 5'd0;
          if (k[0]) f7 = 7'b0001001;
        end
      end
      default: begin
        op = `OP_REG;
        f7 = 7'b0000010;                // Bad funct7
        if (k == 1) begin
          op = `OP_LOAD;
          f3 = 3'd3;
        end
        if (k == 2) begin
          op = `OP_STORE;
          f3 = 3'd4;
        end
        if (k == 3) begin
          op = `OP_BRANCH;
          f3 = 3'd2;
        end
        if (k > 3) op = 7'b1111111;     // Unknown opcode
      end
    endcase
    return assemble(f7, rs2, rs1, f3, rd, op);
  endfunction

  task automatic expectEq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("error time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "Output mismatch");
    end
  endtask

  always @(posedge clk or negedge arstN) begin : shadow
    if (!arstN) begin
      {vD, vE, hE, vM, hM, hW} <= '0;
      {iE, iM, iW} <= '0;
    end else begin
      if (FlushD) vD <= 1'b0;
      else if (!StallD) vD <= 1'b1;
      if (FlushE) {iE, vE, hE} <= '0;
      else if (!StallE) {iE, vE, hE} <= {InstrD, vD, 1'b1};
      if (FlushM) {iM, vM, hM} <= '0;
      else if (!StallM) {iM, vM, hM} <= {iE, vE, hE};
      if (FlushW) {iW, hW} <= '0;
      else if (!StallW) {iW, hW} <= {iM, hM};
    end
  end

  always @(negedge clk) begin : compare
    refCtrlT dD, dE, dM, dW;
    logic [4:0] rdE, rdMx, rdWx;
    logic [1:0] fA, fB;
    logic match, ldSt, stSt, strSt;
    dD = decodeRef(InstrD);
    dE = hE ? decodeRef(iE) : '0;
    dM = hM ? decodeRef(iM) : '0;
    dW = hW ? decodeRef(iW) : '0;
    rdE = hE ? iE[11:7] : 5'd0;
    rdMx = hM ? iM[11:7] : 5'd0;
    rdWx = hW ? iW[11:7] : 5'd0;
    fA = fwdRef(hE ? iE[19:15] : 5'd0, rdMx, dM.regWrite, rdWx, dW.regWrite);
    fB = fwdRef(hE ? iE[24:20] : 5'd0, rdMx, dM.regWrite, rdWx, dW.regWrite);
    match = (InstrD[19:15] == rdE || InstrD[24:20] == rdE) && rdE != 5'd0;
    ldSt = dE.memRw[1] && match;
    stSt = dD.memRw[1] && dE.memRw[0];  // Load behind a store
    strSt = ldSt || stSt || ((dE.csrRead || dE.mdu) && match);
    expectEq("ImmSrcD", 32'(dD.immSrc), 32'(ImmSrcD));
    expectEq("IllegalBaseInstrD", 32'(dD.illegal), 32'(IllegalBaseInstrD));
    expectEq("JumpD", 32'(dD.jump), 32'(JumpD));
    expectEq("BranchD", 32'(dD.branch), 32'(BranchD));
    expectEq("Rs1D", 32'(InstrD[19:15]), 32'(Rs1D));
    expectEq("Rs2D", 32'(InstrD[24:20]), 32'(Rs2D));
    expectEq("PCSrcE", 32'(dE.jump || (dE.branch && takenRef(FlagsE, iE[14:12]))),
             32'(PCSrcE));
    // bltu and bgeu compare unsigned
    expectEq("BranchSignedE", 32'(dE.branch && iE[14:12] != 3'd6 && iE[14:12] != 3'd7),
             32'(BranchSignedE));
    expectEq("MDUActiveE", 32'(dE.mdu), 32'(MDUActiveE));
    expectEq("ForwardAE", 32'(fA), 32'(ForwardAE));
    expectEq("ForwardBE", 32'(fB), 32'(ForwardBE));
    expectEq("LoadStallD", 32'(ldSt), 32'(LoadStallD));
    expectEq("StoreStallD", 32'(stSt), 32'(StoreStallD));
    expectEq("StructuralStallD", 32'(strSt), 32'(StructuralStallD));
    expectEq("MemRWM", 32'(dM.memRw), 32'(MemRWM));
    expectEq("CSRReadM", 32'(dM.csrRead), 32'(CSRReadM));
    expectEq("CSRWriteM", 32'(dM.csrWrite), 32'(CSRWriteM));
    expectEq("PrivilegedM", 32'(hM && privRef(iM)), 32'(PrivilegedM));
    expectEq("InvalidateICacheM", 32'(hM && fenceIRef(iM)), 32'(InvalidateICacheM));
    expectEq("CSRWriteFenceM", 32'(dM.csrWrite || (hM && (fenceIRef(iM) || sfenceRef(iM)))),
             32'(CSRWriteFenceM));
    expectEq("Funct3M", 32'(hM ? iM[14:12] : 3'd0), 32'(Funct3M));
    expectEq("InstrValidM", 32'(vM), 32'(InstrValidM));
    expectEq("RdM", 32'(rdMx), 32'(RdM));
    expectEq("RegWriteW", 32'(dW.regWrite), 32'(RegWriteW));
    expectEq("ResultSrcW", 32'(dW.resultSrc), 32'(ResultSrcW));
    expectEq("IntDivW", 32'(dW.mdu && iW[14]), 32'(IntDivW));
    expectEq("RdW", 32'(rdWx), 32'(RdW));
    nLoadStall += int'(ldSt);
    nOtherStall += int'(strSt && !ldSt);
    nFwdMem += int'(fA == 2'b10);
    nFwdWb += int'(fA == 2'b01);
    nTaken += int'(PCSrcE);
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display(">>> FAIL");
    $fatal(1, "Simulation timed out");
  end

  initial begin : stimulus
    arstN = 1'b0;
    InstrD = '0;
    FlagsE = '0;
    {StallD, FlushD, StallE, FlushE, StallM, FlushM, StallW, FlushW} = '0;
    repeat (RST_CYCLES) @(posedge clk);
    arstN <= 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      @(posedge clk);
      InstrD <= genInstr(pick(12));
      FlagsE <= 2'(pick(4));
      StallD <= (pick(20) == 0);
      StallE <= (pick(20) == 0);
      StallM <= (pick(20) == 0);
      StallW <= (pick(20) == 0);
      FlushD <= (pick(30) == 0);
      FlushE <= (pick(30) == 0);
      FlushM <= (pick(30) == 0);
      FlushW <= (pick(30) == 0);
    end
    @(posedge clk);
    {StallD, FlushD, StallE, FlushE, StallM, FlushM, StallW, FlushW} <= '0;
    InstrD <= genInstr(6);
    repeat (3) @(posedge clk);
    StallM <= 1'b1;                     // Hold Memory
    InstrD <= InstrD ^ 32'h0000_0080;   // Other rd queues up behind it
    @(negedge clk);
    savedRd = RdM;
    repeat (2) @(posedge clk);
    @(negedge clk);
    expectEq("RdM", 32'(savedRd), 32'(RdM));
    @(posedge clk);
    StallM <= 1'b0;
    FlushM <= 1'b1;
    @(posedge clk);
    FlushM <= 1'b0;
    @(negedge clk);
    expectEq("InstrValidM", 32'd0, 32'(InstrValidM));
    covOk = 1'b1;
    assert (nLoadStall > 0 && nOtherStall > 0) else begin
      $display("No load-use or other structural stall was exercised");
      covOk = 1'b0;
    end
    assert (nFwdMem > 0 && nFwdWb > 0 && nTaken > 0) else begin
      $display("Forwarding or redirect cases were never exercised");
      covOk = 1'b0;
    end
    if (covOk) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display(">>> FAIL");
      $fatal(1, "Coverage goals missed");
    end
  end

endmodule

/* filelist.f */
+incdir+.
ctrlPkg.sv
stageReg.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
hazardUnit.sv
controller.sv
tbController.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tbController -f filelist.f -o simv

./obj_dir/simv | tee sim.log || true

if grep -qx ">>> PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
